/* sim.f */
+incdir+hw
hw/game_ui_pkg.sv
hw/game_store_pkg.sv
hw/store_port_if.sv
hw/prog_tick_gen.sv
hw/user_input_sync.sv
hw/record_store.sv
hw/page_menu.sv
hw/page_play.sv
hw/game_top.sv
tb/tb_clock.sv
tb/tb_game.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the game testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_game -f sim.f -o tb_game_sim

./obj_dir/tb_game_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

/* tb/tb_game.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module tb_game;
    localparam int DIV         = `SYS_FREQ / `PROG_FREQ;
    localparam int STEP_CYCLES = `STEP_TICKS * DIV;
    localparam int N_PLAYS     = 3;
    localparam longint LIMIT_NS = longint'(N_PLAYS + 4) * `CHART_LEN * STEP_CYCLES * 100;

    logic       clk;
    logic       sys_rst;
    logic [3:0] btn_arr;
    logic [6:0] btn_notes;
    logic [7:0] seg;
    logic [3:0] seg_sel;
    logic [7:0] led;

    // Reference model of what the menu shows
    bit         check_en = 1'b0;
    int         model_id = 1;
    logic [7:0] model_best [1:`CHART_COUNT];
    logic [7:0] model_last [1:`CHART_COUNT];
    logic [3:0] exp_digit;
    int         cycle_no = 0;
    int         mismatches = 0;
    int         failures = 0;

    tb_clock u_clock (
        .clk     (clk),
        .sys_rst (sys_rst)
    );

    game_top DUT (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .btn_arr   (btn_arr),
        .btn_notes (btn_notes),
        .seg       (seg),
        .seg_sel   (seg_sel),
        .led       (led)
    );

    always @(posedge clk) cycle_no <= cycle_no + 1;

    // Segment pattern back to its hex value or 5'h10 if it is none
    function automatic logic [4:0] seg_to_hex(input logic [7:0] s);
        if (s[7])
            return 5'h10;
        case (s[6:0])
            7'b0111111: return 5'h0;
            7'b0000110: return 5'h1;
            7'b1011011: return 5'h2;
            7'b1001111: return 5'h3;
            7'b1100110: return 5'h4;
            7'b1101101: return 5'h5;
            7'b1111101: return 5'h6;
            7'b0000111: return 5'h7;
            7'b1111111: return 5'h8;
            7'b1101111: return 5'h9;
            7'b1110111: return 5'hA;
            7'b1111100: return 5'hB;
            7'b0111001: return 5'hC;
            7'b1011110: return 5'hD;
            7'b1111001: return 5'hE;
            7'b1110001: return 5'hF;
            default:    return 5'h10;
        endcase
    endfunction

    // Scan starts at digit 0 and rotates upward
    function automatic logic [3:0] next_scan(input logic [3:0] sel);
        return (sel == 4'b0000) ? 4'b0001 : {sel[2:0], sel[3]};
    endfunction

    // One note per step as the built-in charts have
    function automatic logic [6:0] step_mask(input int id, input int s);
        return 7'b1 << ((id + s) % 7);
    endfunction

    always_comb begin
        case (seg_sel)
            4'b1000: exp_digit = 4'(model_id);
            4'b0100: exp_digit = 4'h0;
            4'b0010: exp_digit = model_best[model_id][3:0];
            default: exp_digit = model_last[model_id][3:0];
        endcase
    end

    task automatic log_mismatch(input string msg);
        mismatches++;
        $display("mismatch at %0d ns: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("%s at %0d ns", msg, $time);
    endtask

    scan_onehot: assert property (@(posedge clk) disable iff (sys_rst) $onehot0(seg_sel))
        else log_mismatch("seg_sel is not one-hot");

    scan_order: assert property (@(posedge clk) disable iff (sys_rst)
        (seg_sel != $past(seg_sel)) |-> (seg_sel == next_scan($past(seg_sel))))
        else log_mismatch("display scan out of order");

    seg_valid: assert property (@(posedge clk) disable iff (sys_rst) seg_to_hex(seg) != 5'h10)
        else log_mismatch($sformatf("seg %h is not a hex digit", seg));

    menu_digit: assert property (@(posedge clk) disable iff (sys_rst)
        (check_en && seg_sel != 4'b0000) |-> (seg_to_hex(seg) == {1'b0, exp_digit}))
        else log_mismatch($sformatf("digit select %b expected %h", seg_sel, exp_digit));

    menu_led: assert property (@(posedge clk) disable iff (sys_rst) check_en |-> (led == 8'h00))
        else log_mismatch($sformatf("menu led %h", led));

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic press_arrow(input int idx);
        btn_arr[idx] = 1'b1;
        wait_cycles(DIV);
        btn_arr[idx] = 1'b0;
    endtask

    // Waits until led leaves the given value
    task automatic wait_led_from(input logic [7:0] old, input int limit);
        int n;
        n = 0;
        do begin
            wait_cycles(1);
            n++;
        end while (led == old && n < limit);
        if (led == old)
            report_failure("led did not change in time");
    endtask

    task automatic step_menu(input bit up, input int show_ticks);
        check_en = 1'b0;
        press_arrow(up ? 0 : 1);
        // Sync stages plus the presenting tick and the menu tick
        wait_cycles(2 * DIV);
        if (up)
            model_id = (model_id == `CHART_COUNT) ? 1 : model_id + 1;
        else
            model_id = (model_id == 1) ? `CHART_COUNT : model_id - 1;
        check_en = 1'b1;
        wait_cycles(show_ticks * DIV);
    endtask

    task automatic play_chart(input bit auto_mode, input bit use_notes);
        int         id;
        int         score;
        int         start;
        int         len;
        int         r;
        int         note;
        logic [6:0] mask;
        id       = model_id;
        score    = 0;
        check_en = 1'b0;
        press_arrow(auto_mode ? 3 : 2);
        wait_led_from(8'h00, 4 * STEP_CYCLES);
        for (int s = 0; s < `CHART_LEN; s++) begin
            mask  = step_mask(id, s);
            start = cycle_no;
            assert (led == {auto_mode, mask})
                else log_mismatch($sformatf("step %0d led %h", s, led));
            if (auto_mode) begin
                score++;
            end else if (use_notes) begin
                r = $urandom % 4;
                // Mostly the right key and sometimes any key or none
                if (r != 0) begin
                    note = (r == 3) ? $urandom % 7 : (id + s) % 7;
                    if (mask[note])
                        score++;
                    btn_notes[note] = 1'b1;
                    wait_cycles(2);
                    btn_notes[note] = 1'b0;
                end
            end
            wait_led_from(led, 2 * STEP_CYCLES);
            // Last step also covers the write cycle and the tick back to the menu
            len = (s == `CHART_LEN - 1) ? STEP_CYCLES + DIV : STEP_CYCLES;
            assert (cycle_no - start == len)
                else log_mismatch($sformatf("step %0d lasted %0d cycles", s,
                                            cycle_no - start));
        end
        assert (led == 8'h00)
            else log_mismatch("led not cleared after play");
        model_last[id] = 8'(score);
        if (score > model_best[id])
            model_best[id] = 8'(score);
        check_en = 1'b1;
        wait_cycles(4 * DIV);
    endtask

    initial begin
        btn_arr   = '0;
        btn_notes = '0;
        void'($urandom(32'h29ea_7faf));
        for (int i = 1; i <= `CHART_COUNT; i++) begin
            model_best[i] = '0;
            model_last[i] = '0;
        end
        @(negedge sys_rst);
        assert (seg_sel == 4'b0000 && led == 8'h00)
            else log_mismatch("seg_sel or led not 0 after reset");
        check_en = 1'b1;
        wait_cycles(5 * DIV);

        // Down past the bottom and then up past the top
        step_menu(1'b0, 1);
        step_menu(1'b0, 4);
        repeat (2) step_menu(1'b1, 1);
        step_menu(1'b1, 4);
        repeat (2) step_menu(($urandom & 1) != 0, 4);

        play_chart(1'b1, 1'b0);
        step_menu(1'b1, 1);
        play_chart(1'b0, 1'b1);
        // Back to the auto played chart for a lower score
        step_menu(1'b0, 1);
        play_chart(1'b0, 1'b0);
        repeat (`CHART_COUNT - 1) step_menu(1'b1, 4);

        $display("%0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        report_failure("watchdog expired before the tests finished");
        $display("%0d mismatches, %0d other failures", mismatches, failures);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic sys_rst
);
    initial begin
        clk     = 1'b0;
        sys_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        sys_rst = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* hw/game_top.sv */
`timescale 1ns/1ps

module game_top (
    input  logic       clk,
    input  logic       sys_rst,
    input  logic [3:0] btn_arr,
    input  logic [6:0] btn_notes,
    output logic [7:0] seg,
    output logic [3:0] seg_sel,
    output logic [7:0] led
);
    logic                      tick;
    logic                      page_rst;
    logic                      auto_play;
    logic [7:0]                chart_id;
    game_ui_pkg::user_input_t  user_in;
    game_ui_pkg::page_state_t  state;
    game_ui_pkg::page_output_t menu_out;
    game_ui_pkg::page_output_t play_out;
    game_ui_pkg::page_output_t sel_out;
    logic [3:0]                cur_digit;

    // Active-high segments, bit 0 is a and bit 6 is g
    function automatic logic [6:0] hex_to_seg(input logic [3:0] h);
        case (h)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    store_port_if #(.payload_t(game_store_pkg::chart_t))       chart_port ();
    store_port_if #(.payload_t(game_store_pkg::play_record_t)) record_port ();

    prog_tick_gen u_tick (
        .clk     (clk),
        .sys_rst (sys_rst),
        .tick    (tick)
    );

    user_input_sync u_input (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .tick      (tick),
        .btn_arr   (btn_arr),
        .btn_notes (btn_notes),
        .user_in   (user_in)
    );

    record_store #(
        .payload_t          (game_store_pkg::chart_t),
        .DEFAULT_FROM_CHART (1'b1)
    ) u_chart_store (
        .clk     (clk),
        .sys_rst (sys_rst),
        .port    (chart_port)
    );

    record_store #(
        .payload_t          (game_store_pkg::play_record_t),
        .DEFAULT_FROM_CHART (1'b0)
    ) u_record_store (
        .clk     (clk),
        .sys_rst (sys_rst),
        .port    (record_port)
    );

    // Menu reads both stores, play writes both
    page_menu u_menu (
        .clk         (clk),
        .sys_rst     (sys_rst),
        .tick        (tick),
        .page_rst    (page_rst),
        .user_in     (user_in),
        .chart_port  (chart_port),
        .record_port (record_port),
        .menu_out    (menu_out),
        .auto_play   (auto_play),
        .chart_id    (chart_id)
    );

    page_play u_play (
        .clk         (clk),
        .sys_rst     (sys_rst),
        .tick        (tick),
        .page_rst    (page_rst),
        .user_in     (user_in),
        .cur_chart   (chart_port.read_data),
        .chart_id    (chart_id),
        .auto_play   (auto_play),
        .chart_port  (chart_port),
        .record_port (record_port),
        .play_out    (play_out)
    );

    always_comb begin
        case (state)
            game_ui_pkg::PLAY: sel_out = play_out;
            default:           sel_out = menu_out;
        endcase
    end

    // Page switch on the tick, pages get a reset pulse right after
    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            state    <= game_ui_pkg::MENU;
            page_rst <= 1'b0;
        end else begin
            page_rst <= tick && (sel_out.next_state != state);
            if (tick)
                state <= sel_out.next_state;
        end
    end

    // Digit scan, one position per tick starting at digit 0
    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst)
            seg_sel <= 4'b0000;
        else if (tick)
            seg_sel <= (seg_sel == 4'b0000 || seg_sel[3]) ? 4'b0001 : seg_sel << 1;
    end

    always_comb begin
        case (seg_sel)
            4'b0010: cur_digit = sel_out.digits[1];
            4'b0100: cur_digit = sel_out.digits[2];
            4'b1000: cur_digit = sel_out.digits[3];
            default: cur_digit = sel_out.digits[0];
        endcase
    end

    assign seg = {1'b0, hex_to_seg(cur_digit)};
    assign led = sel_out.led;

endmodule

/* hw/page_play.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module page_play (
    input  logic                      clk,
    input  logic                      sys_rst,
    input  logic                      tick,
    input  logic                      page_rst,
    input  game_ui_pkg::user_input_t  user_in,
    input  game_store_pkg::chart_t    cur_chart,
    input  logic [7:0]                chart_id,
    input  logic                      auto_play,
    store_port_if.writer              chart_port,
    store_port_if.writer              record_port,
    output game_ui_pkg::page_output_t play_out
);
    logic       running;
    logic       finished;
    logic [7:0] step;
    logic [7:0] tick_cnt;
    logic [7:0] score;
    logic       step_hit;
    logic [6:0] mask;
    logic       hit_now;
    logic       step_scored;
    logic [7:0] new_score;

    assign mask        = cur_chart.steps[step];
    assign hit_now     = auto_play | (|(user_in.note_press & mask));
    assign step_scored = step_hit | hit_now;
    // Score as it stands once the current step is closed
    assign new_score   = score + 8'(step_scored);

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            running              <= 1'b0;
            finished             <= 1'b0;
            step                 <= '0;
            tick_cnt             <= '0;
            score                <= '0;
            step_hit             <= 1'b0;
            chart_port.write_id  <= '0;
            record_port.write_id <= '0;
        end else begin
            chart_port.write_id  <= '0;
            record_port.write_id <= '0;
            if (page_rst) begin
                // Same pulse on entry and on exit, finished tells them apart
                if (finished)
                    finished <= 1'b0;
                else
                    running <= 1'b1;
                step     <= '0;
                tick_cnt <= '0;
                score    <= '0;
                step_hit <= 1'b0;
            end else if (tick && running) begin
                if (tick_cnt == `STEP_TICKS - 1) begin
                    tick_cnt <= '0;
                    step_hit <= 1'b0;
                    score    <= new_score;
                    if (step == `CHART_LEN - 1) begin
                        running              <= 1'b0;
                        finished             <= 1'b1;
                        record_port.write_id <= chart_id;
                        if (new_score > cur_chart.best)
                            chart_port.write_id <= chart_id;
                    end else begin
                        step <= step + 8'd1;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 8'd1;
                    step_hit <= step_scored;
                end
            end
        end
    end

    // Write payloads track the running score, the id strobe picks the moment
    always_ff @(posedge clk) begin
        if (tick && running) begin
            record_port.write_data <= '{score: new_score};
            chart_port.write_data  <= '{steps: cur_chart.steps, best: new_score};
        end
    end

    always_comb begin
        play_out.next_state = running ? game_ui_pkg::PLAY : game_ui_pkg::MENU;
        play_out.digits[3]  = chart_id[3:0];
        play_out.digits[2]  = 4'h0;
        play_out.digits[1]  = score[3:0];
        play_out.digits[0]  = step[3:0];
        play_out.led        = {auto_play, mask};
    end

endmodule

/* hw/page_menu.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module page_menu (
    input  logic                      clk,
    input  logic                      sys_rst,
    input  logic                      tick,
    input  logic                      page_rst,
    input  game_ui_pkg::user_input_t  user_in,
    store_port_if.reader              chart_port,
    store_port_if.reader              record_port,
    output game_ui_pkg::page_output_t menu_out,
    output logic                      auto_play,
    output logic [7:0]                chart_id
);
    logic req;
    logic busy;
    logic go;

    // Play or auto play
    assign go = user_in.arr_press[2] | user_in.arr_press[3];

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            chart_id  <= 8'd1;
            auto_play <= 1'b0;
            req       <= 1'b0;
            busy      <= 1'b0;
        end else if (page_rst) begin
            // Entering PLAY sets busy, coming back clears it
            busy <= req;
            req  <= 1'b0;
        end else if (tick && !req && !busy) begin
            if (user_in.arr_press[0])
                chart_id <= (chart_id == `CHART_COUNT) ? 8'd1 : chart_id + 8'd1;
            else if (user_in.arr_press[1])
                chart_id <= (chart_id == 8'd1) ? 8'(`CHART_COUNT) : chart_id - 8'd1;
            if (go) begin
                req       <= 1'b1;
                auto_play <= user_in.arr_press[3];
            end
        end
    end

    assign chart_port.read_id  = chart_id;
    assign record_port.read_id = chart_id;

    always_comb begin
        menu_out.next_state = req ? game_ui_pkg::PLAY : game_ui_pkg::MENU;
        menu_out.digits[3]  = chart_id[3:0];
        menu_out.digits[2]  = 4'h0;
        menu_out.digits[1]  = chart_port.read_data.best[3:0];
        menu_out.digits[0]  = record_port.read_data.score[3:0];
        menu_out.led        = 8'h00;
    end

endmodule

/* hw/record_store.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module record_store #(
    parameter type payload_t          = logic,
    parameter bit  DEFAULT_FROM_CHART = 1'b0
) (
    input logic         clk,
    input logic         sys_rst,
    store_port_if.store port
);
    payload_t mem      [1:`CHART_COUNT];
    payload_t init_val [1:`CHART_COUNT];

    // Power-on contents per entry
    for (genvar g = 1; g <= `CHART_COUNT; g++) begin : g_init
        if (DEFAULT_FROM_CHART) begin : g_chart
            assign init_val[g] = game_store_pkg::default_chart(8'(g));
        end else begin : g_zero
            assign init_val[g] = '0;
        end
    end

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            for (int i = 1; i <= `CHART_COUNT; i++)
                mem[i] <= init_val[i];
        end else if (port.write_id != 0 && port.write_id <= `CHART_COUNT) begin
            mem[port.write_id] <= port.write_data;
        end
    end

    // Out of range ids read as zero
    assign port.read_data = (port.read_id != 0 && port.read_id <= `CHART_COUNT)
                          ? mem[port.read_id] : '0;

endmodule

/* hw/user_input_sync.sv */
`timescale 1ns/1ps

module user_input_sync (
    input  logic                     clk,
    input  logic                     sys_rst,
    input  logic                     tick,
    input  logic [3:0]               btn_arr,
    input  logic [6:0]               btn_notes,
    output game_ui_pkg::user_input_t user_in
);
    logic [10:0] btn_all;
    logic [10:0] sync1;
    logic [10:0] sync2;
    logic [10:0] last_lvl;
    logic [10:0] rise;
    logic [10:0] pending;

    // Same bit order as user_input_t
    assign btn_all = {btn_arr, btn_notes};

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            sync1    <= '0;
            sync2    <= '0;
            last_lvl <= '0;
        end else begin
            sync1    <= btn_all;
            sync2    <= sync1;
            last_lvl <= sync2;
        end
    end

    assign rise = sync2 & ~last_lvl;

    // Edges pile up between ticks so short presses survive
    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            pending <= '0;
            user_in <= '0;
        end else if (tick) begin
            user_in <= game_ui_pkg::user_input_t'(pending);
            // An edge landing on the tick itself goes to the next batch
            pending <= rise;
        end else begin
            pending <= pending | rise;
        end
    end

endmodule

/* hw/prog_tick_gen.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module prog_tick_gen (
    input  logic clk,
    input  logic sys_rst,
    output logic tick
);
    localparam int DIV = `SYS_FREQ / `PROG_FREQ;

    logic [$clog2(DIV+1)-1:0] cnt;

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst)
            cnt <= '0;
        else if (cnt == DIV - 1)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // One cycle enable per period
    assign tick = (cnt == 1);

endmodule

/* hw/store_port_if.sv */
`timescale 1ns/1ps

// Id-addressed access to one store, id 0 means no access
interface store_port_if #(
    parameter type payload_t = logic
);
    logic [7:0] read_id;
    payload_t   read_data;
    logic [7:0] write_id;
    payload_t   write_data;

    modport store (
        input  read_id, write_id, write_data,
        output read_data
    );

    modport reader (
        output read_id,
        input  read_data
    );

    modport writer (output write_id, write_data);

endinterface

/* hw/game_store_pkg.sv */
`include "game_defines.svh"

package game_store_pkg;

    // One 7-bit note mask per step plus the best score so far
    typedef struct packed {
        logic [`CHART_LEN-1:0][6:0] steps;
        logic [7:0]                 best;
    } chart_t;

    // Result of the most recent play of a chart
    typedef struct packed {
        logic [7:0] score;
    } play_record_t;

    // Built-in chart contents, one note per step walking up the keys
    function automatic chart_t default_chart(input logic [7:0] id);
        chart_t c;
        c = '0;
        for (int s = 0; s < `CHART_LEN; s++) begin
            c.steps[s][(id + s) % 7] = 1'b1;
        end
        return c;
    endfunction

endpackage

/* hw/game_ui_pkg.sv */
package game_ui_pkg;

    // Top level pages
    typedef enum logic {
        MENU = 1'b0,
        PLAY = 1'b1
    } page_state_t;

    // Press events, each bit is high for one program tick
    // arr_press: 0 up, 1 down, 2 play, 3 auto play
    typedef struct packed {
        logic [3:0] arr_press;
        logic [6:0] note_press;
    } user_input_t;

    // What a page wants shown and where it wants to go
    typedef struct packed {
        page_state_t     next_state;
        logic [3:0][3:0] digits;
        logic [7:0]      led;
    } page_output_t;

endpackage

/* hw/game_defines.svh */
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// Clock rates in arbitrary units, only the ratio matters
`define SYS_FREQ 1000
`define PROG_FREQ 250

// Program ticks per chart step
`define STEP_TICKS 4

// Number of charts, ids run from 1 to CHART_COUNT
`define CHART_COUNT 4

// Steps in every chart
`define CHART_LEN 8

`endif
